// File: hw/exec_pkg.sv
package exec_pkg;

  // datapath widths
  localparam int XLEN    = 64;
  localparam int WORD_W  = 32;
  localparam int SHAMT_W = 6;
  localparam int REG_W   = 5;
  localparam int INSTR_W = 32;

  // result queue, depth must be a power of two
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

  // alu opcodes carried from decode to the alu
  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLLW,
    ALU_SRLW,
    ALU_SRAW,
    ALU_SLT,
    ALU_SLTU,
    ALU_BEQ,
    ALU_BNE,
    ALU_BLT,
    ALU_BGE,
    ALU_BLTU,
    ALU_BGEU
  } alu_op_e;

  // risc-v major opcodes, instr[6:0]
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_BRANCH    = 7'b1100011;

  // funct7 patterns
  // base ops and the alternate form (sub, sra)
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

// File: hw/alu_shift.sv
module alu_shift import exec_pkg::*; (
  input  logic               shift_sll_i,
  input  logic               shift_srl_i,
  input  logic               shift_sra_i,
  input  logic               is_word_i,
  input  logic [XLEN-1:0]    shift_num_i,
  input  logic [SHAMT_W-1:0] shift_count_i,
  output logic [XLEN-1:0]    shift_out_o
);

  logic               op_shift;
  logic               shift_right;
  logic [XLEN-1:0]    num;
  logic [XLEN-1:0]    num_rev;
  logic [XLEN-1:0]    shl_in;
  logic [XLEN-1:0]    shl_res;
  logic [XLEN-1:0]    srl_res;
  logic [SHAMT_W-1:0] mask_count;
  logic               sign_bit;
  logic [XLEN-1:0]    sra_mask;
  logic [XLEN-1:0]    sra_res;

  assign op_shift    = shift_sll_i | shift_srl_i | shift_sra_i;
  assign shift_right = shift_srl_i | shift_sra_i;

  // word ops see only the low half
  assign num = is_word_i ? {{(XLEN-WORD_W){1'b0}}, shift_num_i[WORD_W-1:0]} : shift_num_i;

  // bit reversal of the operand and of the shifted value
  for (genvar i = 0; i < XLEN; i++) begin : g_rev
    assign num_rev[i] = num[XLEN-1-i];
    assign srl_res[i] = shl_res[XLEN-1-i];
  end

  // right shift becomes a left shift of the reversed operand
  assign shl_in  = {XLEN{op_shift}} & (shift_right ? num_rev : num);
  assign shl_res = shl_in << shift_count_i;

  // sign fill mask
  // word case offsets the count so the fill starts above bit 31
  assign mask_count = is_word_i ? (shift_count_i + SHAMT_W'(WORD_W)) : shift_count_i;
  assign sign_bit   = is_word_i ? num[WORD_W-1] : num[XLEN-1];
  assign sra_mask   = {XLEN{1'b1}} >> mask_count;
  assign sra_res    = (srl_res & sra_mask) | ({XLEN{sign_bit}} & ~sra_mask);

  // one-hot select of the three shift kinds
  assign shift_out_o = ({XLEN{shift_sll_i}} & shl_res) |
                       ({XLEN{shift_srl_i}} & srl_res) |
                       ({XLEN{shift_sra_i}} & sra_res);

endmodule

// File: hw/alu.sv
module alu import exec_pkg::*; (
  input  alu_op_e         alu_op_i,
  input  logic [XLEN-1:0] alu_a_i,
  input  logic [XLEN-1:0] alu_b_i,
  output logic [XLEN-1:0] alu_out_o,
  output logic            compare_out_o
);

  // opcode decode
  logic op_add, op_sub, op_xor, op_or, op_and;
  logic op_sll, op_srl, op_sra, op_sllw, op_srlw, op_sraw;
  logic op_slt, op_sltu;
  logic op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu;

  logic            is_cmp;
  logic            is_sub;
  logic [XLEN:0]   add_a;
  logic [XLEN:0]   add_b;
  logic [XLEN:0]   add_out;
  logic            carry_top;
  logic            flag_zero;
  logic            flag_of;
  logic            flag_sf;
  logic            flag_cf;
  logic            lt_signed;
  logic            lt_unsigned;
  logic            shift_sll;
  logic            shift_srl;
  logic            shift_sra;
  logic            shift_word;
  logic [XLEN-1:0] shift_out;
  logic [XLEN-1:0] main_out;

  assign op_add  = (alu_op_i == ALU_ADD);
  assign op_sub  = (alu_op_i == ALU_SUB);
  assign op_xor  = (alu_op_i == ALU_XOR);
  assign op_or   = (alu_op_i == ALU_OR);
  assign op_and  = (alu_op_i == ALU_AND);
  assign op_sll  = (alu_op_i == ALU_SLL);
  assign op_srl  = (alu_op_i == ALU_SRL);
  assign op_sra  = (alu_op_i == ALU_SRA);
  assign op_sllw = (alu_op_i == ALU_SLLW);
  assign op_srlw = (alu_op_i == ALU_SRLW);
  assign op_sraw = (alu_op_i == ALU_SRAW);
  assign op_slt  = (alu_op_i == ALU_SLT);
  assign op_sltu = (alu_op_i == ALU_SLTU);
  assign op_beq  = (alu_op_i == ALU_BEQ);
  assign op_bne  = (alu_op_i == ALU_BNE);
  assign op_blt  = (alu_op_i == ALU_BLT);
  assign op_bge  = (alu_op_i == ALU_BGE);
  assign op_bltu = (alu_op_i == ALU_BLTU);
  assign op_bgeu = (alu_op_i == ALU_BGEU);

  // every compare runs through the subtractor
  assign is_cmp = op_slt | op_sltu | op_beq | op_bne | op_blt | op_bge | op_bltu | op_bgeu;
  assign is_sub = op_sub | is_cmp;

  // doubled sign bit, b inverted plus carry-in for subtract
  assign add_a   = {alu_a_i[XLEN-1], alu_a_i};
  assign add_b   = {alu_b_i[XLEN-1], alu_b_i} ^ {(XLEN+1){is_sub}};
  assign add_out = add_a + add_b + (XLEN+1)'(is_sub);

  // carry into the top bit equals carry out of bit 63
  assign carry_top = add_a[XLEN] ^ add_b[XLEN] ^ add_out[XLEN];
  assign flag_zero = (add_out == '0);
  assign flag_of   = add_out[XLEN] ^ add_out[XLEN-1];
  assign flag_sf   = add_out[XLEN-1];
  assign flag_cf   = is_sub ^ carry_top;

  assign lt_signed   = flag_sf ^ flag_of;
  // borrow out means a < b unsigned
  assign lt_unsigned = flag_cf;

  // parallel compare mux
  assign compare_out_o = ((op_slt | op_blt) & lt_signed) |
                         ((op_sltu | op_bltu) & lt_unsigned) |
                         (op_bge & ~lt_signed) |
                         (op_bgeu & ~lt_unsigned) |
                         (op_beq & flag_zero) |
                         (op_bne & ~flag_zero);

  // shifter controls
  assign shift_sll  = op_sll | op_sllw;
  assign shift_srl  = op_srl | op_srlw;
  assign shift_sra  = op_sra | op_sraw;
  assign shift_word = op_sllw | op_srlw | op_sraw;

  alu_shift u_alu_shift (
    .shift_sll_i  (shift_sll),
    .shift_srl_i  (shift_srl),
    .shift_sra_i  (shift_sra),
    .is_word_i    (shift_word),
    .shift_num_i  (alu_a_i),
    .shift_count_i(alu_b_i[SHAMT_W-1:0]),
    .shift_out_o  (shift_out)
  );

  // priority select among add, logic and shift
  assign main_out = (op_add | op_sub)                   ? add_out[XLEN-1:0] :
                    op_and                              ? (alu_a_i & alu_b_i) :
                    op_or                               ? (alu_a_i | alu_b_i) :
                    op_xor                              ? (alu_a_i ^ alu_b_i) :
                    (shift_sll | shift_srl | shift_sra) ? shift_out :
                    '0;

  assign alu_out_o = is_cmp ? {{(XLEN-1){1'b0}}, compare_out_o} : main_out;

endmodule

// File: hw/issue_decode.sv
module issue_decode import exec_pkg::*; (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               issue_valid_i,
  input  logic [INSTR_W-1:0] instr_i,
  input  logic [XLEN-1:0]    rs1_val_i,
  input  logic [XLEN-1:0]    rs2_val_i,
  output logic               ex_valid_o,
  output alu_op_e            ex_op_o,
  output logic [XLEN-1:0]    ex_a_o,
  output logic [XLEN-1:0]    ex_b_o,
  output logic [REG_W-1:0]   ex_rd_o,
  output logic               ex_is_branch_o,
  output logic               ex_is_word_o,
  output logic               illegal_o
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic            dec_legal;
  alu_op_e         dec_op;
  logic [XLEN-1:0] dec_b;
  logic            dec_branch;
  logic            dec_word;
  logic            illegal_q;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  // sign-extended I immediate
  assign imm_i  = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};

  always_comb begin
    dec_legal  = 1'b0;
    dec_op     = ALU_ADD;
    dec_b      = rs2_val_i;
    dec_branch = 1'b0;
    dec_word   = 1'b0;
    case (opcode)
      OPC_OP: begin
        if (funct7 == F7_BASE) begin
          dec_legal = 1'b1;
          case (funct3)
            3'b000: dec_op = ALU_ADD;
            3'b001: dec_op = ALU_SLL;
            3'b010: dec_op = ALU_SLT;
            3'b011: dec_op = ALU_SLTU;
            3'b100: dec_op = ALU_XOR;
            3'b101: dec_op = ALU_SRL;
            3'b110: dec_op = ALU_OR;
            default: dec_op = ALU_AND;
          endcase
        end else if (funct7 == F7_ALT) begin
          // only sub and sra have the alternate funct7
          dec_legal = (funct3 == 3'b000) || (funct3 == 3'b101);
          dec_op    = (funct3 == 3'b000) ? ALU_SUB : ALU_SRA;
        end
      end
      OPC_OP_IMM: begin
        dec_b     = imm_i;
        dec_legal = 1'b1;
        case (funct3)
          3'b000: dec_op = ALU_ADD;
          3'b010: dec_op = ALU_SLT;
          3'b011: dec_op = ALU_SLTU;
          3'b100: dec_op = ALU_XOR;
          3'b110: dec_op = ALU_OR;
          3'b111: dec_op = ALU_AND;
          3'b001: begin
            dec_op    = ALU_SLL;
            dec_legal = (instr_i[31:26] == F7_BASE[6:1]);
          end
          default: begin
            // 6-bit shamt, funct6 picks srli or srai
            dec_op    = instr_i[30] ? ALU_SRA : ALU_SRL;
            dec_legal = (instr_i[31:26] == F7_BASE[6:1]) || (instr_i[31:26] == F7_ALT[6:1]);
          end
        endcase
      end
      OPC_OP_32, OPC_OP_IMM_32: begin
        dec_word = 1'b1;
        // word shift count is 5 bits
        dec_b = (opcode == OPC_OP_32) ? XLEN'(rs2_val_i[SHAMT_W-2:0]) :
                                        XLEN'(instr_i[24:20]);
        dec_op    = (funct3 == 3'b001) ? ALU_SLLW : (funct7 == F7_ALT) ? ALU_SRAW : ALU_SRLW;
        dec_legal = ((funct3 == 3'b001) && (funct7 == F7_BASE)) ||
                    ((funct3 == 3'b101) && ((funct7 == F7_BASE) || (funct7 == F7_ALT)));
      end
      OPC_BRANCH: begin
        dec_branch = 1'b1;
        dec_legal  = (funct3 != 3'b010) && (funct3 != 3'b011);
        case (funct3)
          3'b000: dec_op = ALU_BEQ;
          3'b001: dec_op = ALU_BNE;
          3'b100: dec_op = ALU_BLT;
          3'b101: dec_op = ALU_BGE;
          3'b110: dec_op = ALU_BLTU;
          default: dec_op = ALU_BGEU;
        endcase
      end
      default: dec_legal = 1'b0;
    endcase
  end

  // strobes; illegal reports one cycle after the slot would load
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ex_valid_o <= 1'b0;
      illegal_q  <= 1'b0;
      illegal_o  <= 1'b0;
    end else begin
      ex_valid_o <= issue_valid_i & dec_legal;
      illegal_q  <= issue_valid_i & ~dec_legal;
      illegal_o  <= illegal_q;
    end
  end

  // issue slot payload
  always_ff @(posedge clk_i) begin
    if (issue_valid_i && dec_legal) begin
      ex_op_o        <= dec_op;
      ex_a_o         <= rs1_val_i;
      ex_b_o         <= dec_b;
      // branches carry no destination
      ex_rd_o        <= dec_branch ? '0 : instr_i[11:7];
      ex_is_branch_o <= dec_branch;
      ex_is_word_o   <= dec_word;
    end
  end

endmodule

// File: hw/result_fifo.sv
module result_fifo import exec_pkg::*; (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             push_i,
  input  logic [XLEN-1:0]  push_data_i,
  input  logic             push_taken_i,
  input  logic [REG_W-1:0] push_rd_i,
  input  logic             push_is_branch_i,
  input  logic             push_is_word_i,
  input  logic             pop_i,
  output logic [XLEN-1:0]  head_data_o,
  output logic             head_taken_o,
  output logic [REG_W-1:0] head_rd_o,
  output logic             head_is_branch_o,
  output logic             head_is_word_o,
  output logic             empty_o,
  output logic             full_o,
  output logic             overflow_o
);

  // entry storage
  logic [XLEN-1:0]  mem_data   [FIFO_DEPTH];
  logic             mem_taken  [FIFO_DEPTH];
  logic [REG_W-1:0] mem_rd     [FIFO_DEPTH];
  logic             mem_branch [FIFO_DEPTH];
  logic             mem_word   [FIFO_DEPTH];

  // pointers carry one wrap bit above the index
  logic [FIFO_AW:0] wr_ptr;
  logic [FIFO_AW:0] rd_ptr;
  logic             push_ok;
  logic             pop_ok;

  assign empty_o = (wr_ptr == rd_ptr);
  assign full_o  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                   (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);
  assign push_ok = push_i & ~full_o;
  assign pop_ok  = pop_i & ~empty_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      overflow_o <= 1'b0;
    end else begin
      wr_ptr     <= wr_ptr + (FIFO_AW+1)'(push_ok);
      rd_ptr     <= rd_ptr + (FIFO_AW+1)'(pop_ok);
      // push into a full queue is lost
      overflow_o <= push_i & full_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_data[wr_ptr[FIFO_AW-1:0]]   <= push_data_i;
      mem_taken[wr_ptr[FIFO_AW-1:0]]  <= push_taken_i;
      mem_rd[wr_ptr[FIFO_AW-1:0]]     <= push_rd_i;
      mem_branch[wr_ptr[FIFO_AW-1:0]] <= push_is_branch_i;
      mem_word[wr_ptr[FIFO_AW-1:0]]   <= push_is_word_i;
    end
  end

  // head of queue
  assign head_data_o      = mem_data[rd_ptr[FIFO_AW-1:0]];
  assign head_taken_o     = mem_taken[rd_ptr[FIFO_AW-1:0]];
  assign head_rd_o        = mem_rd[rd_ptr[FIFO_AW-1:0]];
  assign head_is_branch_o = mem_branch[rd_ptr[FIFO_AW-1:0]];
  assign head_is_word_o   = mem_word[rd_ptr[FIFO_AW-1:0]];

endmodule

// File: hw/wb_commit.sv
module wb_commit import exec_pkg::*; (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             wb_stall_i,
  input  logic [XLEN-1:0]  head_data_i,
  input  logic             head_taken_i,
  input  logic [REG_W-1:0] head_rd_i,
  input  logic             head_is_branch_i,
  input  logic             head_is_word_i,
  input  logic             empty_i,
  output logic             pop_o,
  output logic             wb_valid_o,
  output logic [REG_W-1:0] wb_rd_o,
  output logic [XLEN-1:0]  wb_data_o,
  output logic             br_valid_o,
  output logic             br_taken_o
);

  logic [XLEN-1:0] data_ext;

  // drain whenever something is queued and we are not held
  assign pop_o = ~empty_i & ~wb_stall_i;

  // word results sign-extend from bit 31
  assign data_ext = head_is_word_i ?
                    {{(XLEN-WORD_W){head_data_i[WORD_W-1]}}, head_data_i[WORD_W-1:0]} :
                    head_data_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_valid_o <= 1'b0;
      br_valid_o <= 1'b0;
    end else begin
      br_valid_o <= pop_o & head_is_branch_i;
      // x0 writes are dropped
      wb_valid_o <= pop_o & ~head_is_branch_i & (head_rd_i != '0);
    end
  end

  // commit payload
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      wb_rd_o    <= head_rd_i;
      wb_data_o  <= data_ext;
      br_taken_o <= head_taken_i;
    end
  end

endmodule

// File: hw/exec_unit.sv
module exec_unit import exec_pkg::*; (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               issue_valid_i,
  input  logic [INSTR_W-1:0] instr_i,
  input  logic [XLEN-1:0]    rs1_val_i,
  input  logic [XLEN-1:0]    rs2_val_i,
  input  logic               wb_stall_i,
  output logic               wb_valid_o,
  output logic [REG_W-1:0]   wb_rd_o,
  output logic [XLEN-1:0]    wb_data_o,
  output logic               br_valid_o,
  output logic               br_taken_o,
  output logic               fifo_full_o,
  output logic               overflow_o,
  output logic               illegal_o
);

  // issue slot
  logic             ex_valid;
  alu_op_e          ex_op;
  logic [XLEN-1:0]  ex_a;
  logic [XLEN-1:0]  ex_b;
  logic [REG_W-1:0] ex_rd;
  logic             ex_is_branch;
  logic             ex_is_word;

  // alu results
  logic [XLEN-1:0]  alu_out;
  logic             compare_out;

  // queue head
  logic [XLEN-1:0]  q_data;
  logic             q_taken;
  logic [REG_W-1:0] q_rd;
  logic             q_is_branch;
  logic             q_is_word;
  logic             q_empty;
  logic             q_pop;

  issue_decode u_issue_decode (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .issue_valid_i (issue_valid_i),
    .instr_i       (instr_i),
    .rs1_val_i     (rs1_val_i),
    .rs2_val_i     (rs2_val_i),
    .ex_valid_o    (ex_valid),
    .ex_op_o       (ex_op),
    .ex_a_o        (ex_a),
    .ex_b_o        (ex_b),
    .ex_rd_o       (ex_rd),
    .ex_is_branch_o(ex_is_branch),
    .ex_is_word_o  (ex_is_word),
    .illegal_o     (illegal_o)
  );

  alu u_alu (
    .alu_op_i     (ex_op),
    .alu_a_i      (ex_a),
    .alu_b_i      (ex_b),
    .alu_out_o    (alu_out),
    .compare_out_o(compare_out)
  );

  // alu result captured on the issue slot strobe
  result_fifo u_result_fifo (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .push_i          (ex_valid),
    .push_data_i     (alu_out),
    .push_taken_i    (compare_out),
    .push_rd_i       (ex_rd),
    .push_is_branch_i(ex_is_branch),
    .push_is_word_i  (ex_is_word),
    .pop_i           (q_pop),
    .head_data_o     (q_data),
    .head_taken_o    (q_taken),
    .head_rd_o       (q_rd),
    .head_is_branch_o(q_is_branch),
    .head_is_word_o  (q_is_word),
    .empty_o         (q_empty),
    .full_o          (fifo_full_o),
    .overflow_o      (overflow_o)
  );

  wb_commit u_wb_commit (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .wb_stall_i      (wb_stall_i),
    .head_data_i     (q_data),
    .head_taken_i    (q_taken),
    .head_rd_i       (q_rd),
    .head_is_branch_i(q_is_branch),
    .head_is_word_i  (q_is_word),
    .empty_i         (q_empty),
    .pop_o           (q_pop),
    .wb_valid_o      (wb_valid_o),
    .wb_rd_o         (wb_rd_o),
    .wb_data_o       (wb_data_o),
    .br_valid_o      (br_valid_o),
    .br_taken_o      (br_taken_o)
  );

endmodule

// File: testbench/exec_unit_asserts.sv
module exec_unit_asserts (
  input logic clk_i,
  input logic reset_i,
  input logic full_i,
  input logic empty_i,
  input logic pop_i,
  input logic wb_valid_i,
  input logic br_valid_i,
  input logic stall_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // queue state is never both full and empty
  full_empty_excl: assert property (@(posedge clk_i) disable iff (reset_i)
    !(full_i && empty_i))
    else $error("fifo reports full and empty together");

  // a commit is either a write or a branch
  one_commit_kind: assert property (@(posedge clk_i) disable iff (reset_i)
    !(wb_valid_i && br_valid_i))
    else $error("write and branch commit in the same cycle");

  // commit needs a pop, which needs stall low the cycle before
  no_commit_on_stall: assert property (@(posedge clk_i) disable iff (reset_i)
    (wb_valid_i || br_valid_i) |-> !$past(stall_i))
    else $error("commit after a stalled cycle");

  no_pop_when_empty: assert property (@(posedge clk_i) disable iff (reset_i)
    pop_i |-> !empty_i)
    else $error("pop while the fifo is empty");

endmodule

// fifo side, commit signals tied off
bind result_fifo exec_unit_asserts u_fifo_asserts (
  .clk_i     (clk_i),
  .reset_i   (reset_i),
  .full_i    (full_o),
  .empty_i   (empty_o),
  .pop_i     (pop_i),
  .wb_valid_i(1'b0),
  .br_valid_i(1'b0),
  .stall_i   (1'b0)
);

// commit side, full flag not visible here
bind wb_commit exec_unit_asserts u_commit_asserts (
  .clk_i     (clk_i),
  .reset_i   (reset_i),
  .full_i    (1'b0),
  .empty_i   (empty_i),
  .pop_i     (pop_o),
  .wb_valid_i(wb_valid_o),
  .br_valid_i(br_valid_o),
  .stall_i   (wb_stall_i)
);

// File: testbench/tb_exec_unit.sv
module tb_exec_unit import exec_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 500;

  typedef struct packed {
    logic            legal;
    logic            is_branch;
    logic            commit;
    logic            taken;
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
  } exp_t;

  logic               clk_i;
  logic               reset_i;
  logic               issue_valid_i;
  logic [31:0]        instr_i;
  logic [XLEN-1:0]    rs1_val_i;
  logic [XLEN-1:0]    rs2_val_i;
  logic               wb_stall_i;
  logic               wb_valid_o;
  logic [4:0]         wb_rd_o;
  logic [XLEN-1:0]    wb_data_o;
  logic               br_valid_o;
  logic               br_taken_o;
  logic               fifo_full_o;
  logic               overflow_o;
  logic               illegal_o;

  exp_t  exp_q[$];
  exp_t  s1;
  exp_t  s2;
  logic  s1_v;
  logic  s2_v;
  logic  s2_drop;
  int    occ;
  logic  stall_en;
  int    errors;
  int    checks;
  int    drops;
  int    ill_expected;
  int    ill_seen;
  int    err_at_start;
  string test_name;

  exec_unit u_dut (.*);

  always #2 clk_i = ~clk_i;

  // random back-pressure, mostly stalled so the queue fills
  always @(posedge clk_i) begin
    wb_stall_i <= stall_en ? (($urandom % 4) != 0) : 1'b0;
  end

  // expected commit from the instruction fields and operands
  function automatic exp_t ref_model(input logic [31:0] ins, input logic [XLEN-1:0] a,
                                     input logic [XLEN-1:0] b);
    exp_t            e;
    logic [6:0]      opc;
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic [XLEN-1:0] imm;
    logic [4:0]      sh;
    logic [31:0]     w;
    opc = ins[6:0];
    f3  = ins[14:12];
    f7  = ins[31:25];
    imm = {{(XLEN-12){ins[31]}}, ins[31:20]};
    e   = '0;
    e.legal = 1'b1;
    e.rd    = ins[11:7];
    case (opc)
      OPC_OP: begin
        if (f7 == 7'h00) begin
          case (f3)
            3'd0: e.data = a + b;
            3'd1: e.data = a << b[5:0];
            3'd2: e.data = XLEN'($signed(a) < $signed(b));
            3'd3: e.data = XLEN'(a < b);
            3'd4: e.data = a ^ b;
            3'd5: e.data = a >> b[5:0];
            3'd6: e.data = a | b;
            default: e.data = a & b;
          endcase
        end else if (f7 == 7'h20 && f3 == 3'd0) e.data = a - b;
        else if (f7 == 7'h20 && f3 == 3'd5) e.data = $signed(a) >>> b[5:0];
        else e.legal = 1'b0;
      end
      OPC_OP_IMM: begin
        case (f3)
          3'd0: e.data = a + imm;
          3'd2: e.data = XLEN'($signed(a) < $signed(imm));
          3'd3: e.data = XLEN'(a < imm);
          3'd4: e.data = a ^ imm;
          3'd6: e.data = a | imm;
          3'd7: e.data = a & imm;
          3'd1: begin
            e.legal = (ins[31:26] == 6'b000000);
            e.data  = a << ins[25:20];
          end
          default: begin
            e.legal = (ins[31:26] == 6'b000000) || (ins[31:26] == 6'b010000);
            // srai keeps the sign, srli fills with zero
            if (ins[30]) e.data = $signed(a) >>> ins[25:20];
            else e.data = a >> ins[25:20];
          end
        endcase
      end
      OPC_OP_32, OPC_OP_IMM_32: begin
        // word shifts use a 5-bit count
        sh = (opc == OPC_OP_32) ? b[4:0] : ins[24:20];
        if (f3 == 3'd1 && f7 == 7'h00) w = a[31:0] << sh;
        else if (f3 == 3'd5 && f7 == 7'h00) w = a[31:0] >> sh;
        else if (f3 == 3'd5 && f7 == 7'h20) w = $signed(a[31:0]) >>> sh;
        else e.legal = 1'b0;
        e.data = {{32{w[31]}}, w};
      end
      OPC_BRANCH: begin
        e.is_branch = 1'b1;
        case (f3)
          3'd0: e.taken = (a == b);
          3'd1: e.taken = (a != b);
          3'd4: e.taken = $signed(a) < $signed(b);
          3'd5: e.taken = $signed(a) >= $signed(b);
          3'd6: e.taken = a < b;
          3'd7: e.taken = a >= b;
          default: e.legal = 1'b0;
        endcase
      end
      default: e.legal = 1'b0;
    endcase
    e.commit = e.legal && !e.is_branch && (e.rd != 5'd0);
    return e;
  endfunction

  task automatic check(input string name, input logic [XLEN-1:0] exp_v,
                       input logic [XLEN-1:0] act_v);
    checks++;
    if (exp_v !== act_v) begin
      errors++;
      $display("** Error %s expected %h actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s in test %s", what, test_name);
    $display("STATUS: FAIL");
    $finish;
  endtask

  // monitor; follows each issue through the slot and the fifo push
  always @(posedge clk_i) begin
    exp_t e;
    logic pop_now;
    logic drop_now;
    if (reset_i) begin
      s1_v    = 1'b0;
      s2_v    = 1'b0;
      s2_drop = 1'b0;
      occ     = 0;
    end else begin
      if (wb_valid_o || br_valid_o) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("test %s saw a commit with no result outstanding", test_name);
        end else begin
          e = exp_q.pop_front();
          check({test_name, " branch"}, XLEN'(e.is_branch), XLEN'(br_valid_o));
          if (e.is_branch) begin
            check({test_name, " taken"}, XLEN'(e.taken), XLEN'(br_taken_o));
          end else begin
            check({test_name, " rd"}, XLEN'(e.rd), XLEN'(wb_rd_o));
            check({test_name, " data"}, e.data, wb_data_o);
          end
        end
      end
      // overflow_o belongs to the push one edge earlier
      check({test_name, " overflow"}, XLEN'(s2_v && s2_drop), XLEN'(overflow_o));
      if (s2_v) begin
        if (s2_drop) drops++;
        else if (s2.commit || s2.is_branch) exp_q.push_back(s2);
      end
      // queue occupancy model
      // the slot pushes on this edge, an unstalled edge pops the head
      check({test_name, " full"}, XLEN'(occ == FIFO_DEPTH), XLEN'(fifo_full_o));
      pop_now  = (occ != 0) && !wb_stall_i;
      drop_now = s1_v && (occ == FIFO_DEPTH);
      occ      = occ + int'(s1_v && !drop_now) - int'(pop_now);
      s2       = s1;
      s2_v     = s1_v;
      s2_drop  = drop_now;
      s1_v     = 1'b0;
      if (issue_valid_i) begin
        e = ref_model(instr_i, rs1_val_i, rs2_val_i);
        if (e.legal) begin
          s1   = e;
          s1_v = 1'b1;
        end else begin
          ill_expected++;
        end
      end
      if (illegal_o) ill_seen++;
    end
  end

  function automatic logic [XLEN-1:0] rand_operand();
    logic [XLEN-1:0] corner [7];
    corner = '{64'd0, 64'd1, '1, 64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff,
               64'h0000_0000_8000_0000, 64'hffff_ffff_7fff_ffff};
    if (($urandom % 3) == 0) return corner[$urandom % 7];
    return {$urandom, $urandom};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    return {f7, 5'd2, 5'd1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] opc);
    return {imm, 5'd1, f3, rd, opc};
  endfunction

  task automatic issue(input logic [31:0] ins, input logic [XLEN-1:0] a,
                       input logic [XLEN-1:0] b);
    @(posedge clk_i);
    issue_valid_i <= 1'b1;
    instr_i       <= ins;
    rs1_val_i     <= a;
    rs2_val_i     <= b;
  endtask

  // idle the input, then wait for all outstanding results
  task automatic drain();
    int n;
    @(posedge clk_i);
    issue_valid_i <= 1'b0;
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
    end while ((exp_q.size() != 0 || s1_v || s2_v) && n < TIMEOUT);
    if (n >= TIMEOUT) stop_on_timeout("outstanding commits");
    repeat (8) @(negedge clk_i);
  endtask

  task automatic start_test(input string name);
    test_name    = name;
    err_at_start = errors;
  endtask

  task automatic end_test();
    $display("test %-10s done, %0d errors", test_name, errors - err_at_start);
  endtask

  initial begin
    int lat;
    logic seen;
    logic [2:0] f3;
    logic [XLEN-1:0] op_a;
    clk_i         = 1'b0;
    reset_i       = 1'b1;
    issue_valid_i = 1'b0;
    instr_i       = '0;
    rs1_val_i     = '0;
    rs2_val_i     = '0;
    wb_stall_i    = 1'b0;
    stall_en      = 1'b0;
    void'($urandom(32'hf88c_90d4));
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;

    start_test("arith");
    for (int i = 0; i < 60; i++) begin
      f3 = 3'(4 + ($urandom % 4));
      if (f3 == 3'd5) f3 = 3'd0;
      case ($urandom % 3)
        0: issue(enc_r(7'h00, f3, 5'($urandom), OPC_OP), rand_operand(), rand_operand());
        1: issue(enc_r(7'h20, 3'd0, 5'($urandom), OPC_OP), rand_operand(), rand_operand());
        default: issue(enc_i(12'($urandom), f3, 5'($urandom), OPC_OP_IMM), rand_operand(), 0);
      endcase
    end
    drain();
    end_test();

    start_test("shift");
    for (int i = 0; i < 60; i++) begin
      case ($urandom % 6)
        0: issue(enc_r(7'h00, 3'd1, 5'($urandom), OPC_OP), rand_operand(), rand_operand());
        1: issue(enc_r(7'h20, 3'd5, 5'($urandom), OPC_OP), rand_operand(), rand_operand());
        2: issue(enc_i({6'b010000, 6'($urandom)}, 3'd5, 5'($urandom), OPC_OP_IMM),
                 rand_operand(), 0);
        3: issue(enc_i({6'b000000, 6'd63}, 3'($urandom % 2 ? 1 : 5), 5'd9, OPC_OP_IMM),
                 rand_operand(), 0);
        4: issue(enc_r(($urandom % 2) ? 7'h20 : 7'h00, 3'd5, 5'($urandom), OPC_OP_32),
                 rand_operand(), rand_operand());
        default: issue(enc_i({7'h00, 5'($urandom)}, 3'd1, 5'($urandom), OPC_OP_IMM_32),
                       rand_operand(), 0);
      endcase
    end
    drain();
    end_test();

    start_test("compare");
    for (int i = 0; i < 80; i++) begin
      f3 = 3'($urandom);
      if (f3 == 3'd2 || f3 == 3'd3) f3 = 3'd4;
      case ($urandom % 3)
        0: issue(enc_r(7'h00, 3'(2 + ($urandom % 2)), 5'($urandom), OPC_OP),
                 rand_operand(), rand_operand());
        1: issue(enc_i(12'($urandom), 3'(2 + ($urandom % 2)), 5'($urandom), OPC_OP_IMM),
                 rand_operand(), 0);
        default: begin
          // equal operands now and then so beq and bne see both outcomes
          op_a = rand_operand();
          issue(enc_r(7'h00, f3, 5'($urandom), OPC_BRANCH), op_a,
                (($urandom % 4) == 0) ? op_a : rand_operand());
        end
      endcase
    end
    drain();
    end_test();

    start_test("latency");
    issue(enc_r(7'h00, 3'd0, 5'd5, OPC_OP), 64'd20, 64'd22);
    lat  = 0;
    seen = 1'b0;
    while (!seen && lat < TIMEOUT) begin
      @(posedge clk_i);
      issue_valid_i <= 1'b0;
      lat++;
      seen = wb_valid_o;
    end
    if (!seen) stop_on_timeout("single commit");
    // first loop edge is the one that samples the issue
    check("latency edges", 64'd3, XLEN'(lat - 1));
    // x0 destination must not commit
    issue(enc_r(7'h00, 3'd0, 5'd0, OPC_OP), 64'd1, 64'd2);
    drain();
    end_test();

    start_test("backpress");
    drops = 0;
    @(negedge clk_i);
    stall_en = 1'b1;
    for (int i = 0; i < 40; i++) begin
      issue(enc_r(7'h00, 3'd0, 5'(1 + (i % 31)), OPC_OP), rand_operand(), XLEN'(i));
    end
    @(negedge clk_i);
    stall_en = 1'b0;
    drain();
    check("overflow seen", 64'd1, XLEN'(drops > 0));
    end_test();

    start_test("illegal");
    ill_expected = 0;
    ill_seen     = 0;
    issue(enc_r(7'h00, 3'd0, 5'd3, OPC_OP_32), 64'd5, 64'd6);
    issue(enc_i(12'd8, 3'd3, 5'd4, 7'b0000011), 64'd5, 0);
    @(posedge clk_i);
    issue_valid_i <= 1'b0;
    lat = 0;
    while (ill_seen < 2 && lat < TIMEOUT) begin
      @(negedge clk_i);
      lat++;
    end
    if (ill_seen < 2) stop_on_timeout("illegal pulses");
    drain();
    check("illegal count", XLEN'(ill_expected), XLEN'(ill_seen));
    end_test();

    $display("checks %0d, errors %0d, dropped %0d", checks, errors, drops);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: flist.f
hw/exec_pkg.sv
hw/alu_shift.sv
hw/alu.sv
hw/issue_decode.sv
hw/result_fifo.sv
hw/wb_commit.sv
hw/exec_unit.sv
testbench/exec_unit_asserts.sv
testbench/tb_exec_unit.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_exec_unit -f flist.f

# the log decides the outcome, so a stopped run is still inspected
./obj_dir/Vtb_exec_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
  echo "simulation did not finish"
  exit 1
fi
echo "simulation passed"
